/* list.f */
+incdir+include
design/udp_rx_pkg.sv
design/udp_csum_lane.sv
design/udp_rx_header_parser.sv
design/udp_csum_verdict.sv
design/udp_rx_forwarder.sv
design/udp_rx_top.sv
tests/udp_rx_tb.sv

/* tests/udp_rx_tb.sv */
`timescale 1ns/1ps
`include "udp_rx_macros.svh"

module udp_rx_tb;
    import udp_rx_pkg::*;

    logic                      rx_axis_aclk;
    logic                      rx_axis_aresetn;
    logic [`UDP_RX_DATA_W-1:0] ip_rx_axis_tdata;
    logic [`UDP_RX_KEEP_W-1:0] ip_rx_axis_tkeep;
    logic                      ip_rx_axis_tvalid;
    logic                      ip_rx_axis_tlast;
    logic                      ip_rx_axis_tuser;
    logic [31:0]               recv_dst_ip_addr;
    logic [31:0]               recv_src_ip_addr;
    logic [`UDP_RX_DATA_W-1:0] udp_rx_axis_tdata;
    logic [`UDP_RX_KEEP_W-1:0] udp_rx_axis_tkeep;
    logic                      udp_rx_axis_tvalid;
    logic                      udp_rx_axis_tlast;

    ip_beat_t    exp_q[$];
    ip_beat_t    exp_beat;
    string       test_name;
    logic [31:0] lfsr;
    logic [31:0] rnd;
    logic [31:0] gap;
    int          err_data;
    int          err_keep;
    int          err_last;
    int          err_other;

    udp_rx_top i_dut (.*);

    initial rx_axis_aclk = 1'b0;
    always #20 rx_axis_aclk = ~rx_axis_aclk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // end-around carry until the sum fits in 16 bits
    function automatic logic [15:0] fold16(input logic [31:0] acc);
        logic [31:0] t;
        t = acc;
        while (t[31:16] != 16'h0) begin
            t = {16'h0, t[15:0]} + {16'h0, t[31:16]};
        end
        return t[15:0];
    endfunction

    function automatic logic [63:0] keep_mask(input logic [7:0] k);
        logic [63:0] m;
        for (int j = 0; j < 8; j++) begin
            m[8*j +: 8] = {8{k[j]}};
        end
        return m;
    endfunction

    task automatic drive_beat(input logic [63:0] d, input logic [7:0] k, input logic l,
                              input logic u);
        @(posedge rx_axis_aclk);
        #1;
        ip_rx_axis_tdata  = d;
        ip_rx_axis_tkeep  = k;
        ip_rx_axis_tvalid = 1'b1;
        ip_rx_axis_tlast  = l;
        ip_rx_axis_tuser  = u;
    endtask

    task automatic drive_idle();
        @(posedge rx_axis_aclk);
        #1;
        ip_rx_axis_tdata  = '0;
        ip_rx_axis_tkeep  = '0;
        ip_rx_axis_tvalid = 1'b0;
        ip_rx_axis_tlast  = 1'b0;
        ip_rx_axis_tuser  = 1'b0;
    endtask

    // builds one packet, queues its expected output and drives it
    task automatic send_packet(input int pay_len, input int pad_len, input bit flip,
                               input bit bad_user, input int pre_gap);
        logic [7:0]  bytes[$];
        logic [63:0] beats[$];
        logic [63:0] d;
        logic [31:0] v;
        logic [31:0] acc;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] udp_len;
        logic [15:0] csum;
        logic [7:0]  k;
        ip_beat_t    b;
        int          n_bytes;
        int          n_out;
        int          tail;
        for (int i = 0; i < pay_len; i++) begin
            take_bits(8, v);
            bytes.push_back(v[7:0]);
        end
        for (int i = 0; i < pad_len; i++) begin
            bytes.push_back(8'h00);
        end
        n_bytes = bytes.size();
        take_bits(16, v);
        src_port = v[15:0];
        take_bits(16, v);
        dst_port = v[15:0];
        udp_len = 16'(pay_len + 8);
        repeat (pre_gap) drive_idle();
        take_bits(32, recv_src_ip_addr);
        take_bits(32, recv_dst_ip_addr);
        // pseudo-header, then header words with a zero checksum field
        acc = recv_src_ip_addr[31:16] + recv_src_ip_addr[15:0] + recv_dst_ip_addr[31:16]
            + recv_dst_ip_addr[15:0] + 32'd17 + udp_len + src_port + dst_port + udp_len;
        for (int i = 0; i < n_bytes; i += 2) begin
            acc = acc + {16'h0, bytes[i], (i + 1 < n_bytes) ? bytes[i+1] : 8'h00};
        end
        csum = ~fold16(acc);
        if (flip) begin
            bytes[0] = bytes[0] ^ 8'hff;
        end
        for (int b_i = 0; b_i < (n_bytes + 7) / 8; b_i++) begin
            d = '0;
            for (int j = 0; j < 8; j++) begin
                if (8 * b_i + j < n_bytes) begin
                    d[8*j +: 8] = bytes[8*b_i + j];
                end else begin
                    // junk in bytes past tkeep
                    d[8*j +: 8] = 8'hc3;
                end
            end
            beats.push_back(d);
        end
        if (!flip && !bad_user) begin
            n_out = (pay_len + 7) / 8;
            tail = pay_len % 8;
            for (int i = 0; i < n_out; i++) begin
                b.tdata = beats[i];
                b.tlast = (i == n_out - 1);
                b.tkeep = (b.tlast && tail != 0) ? 8'((1 << tail) - 1) : 8'hff;
                exp_q.push_back(b);
            end
        end
        // byte 0 sits in the low bits of tdata
        drive_beat({csum[7:0], csum[15:8], udp_len[7:0], udp_len[15:8],
                    dst_port[7:0], dst_port[15:8], src_port[7:0], src_port[15:8]},
                   8'hff, 1'b0, 1'b0);
        for (int i = 0; i < beats.size(); i++) begin
            if (i == beats.size() - 1) begin
                k = (n_bytes % 8 == 0) ? 8'hff : 8'((1 << (n_bytes % 8)) - 1);
                drive_beat(beats[i], k, 1'b1, bad_user);
            end else begin
                drive_beat(beats[i], 8'hff, 1'b0, 1'b0);
            end
        end
        drive_idle();
    endtask

    task automatic wait_drain(input int limit);
        int cnt;
        cnt = 0;
        while (exp_q.size() != 0 && cnt < limit) begin
            @(posedge rx_axis_aclk);
            cnt++;
        end
        if (exp_q.size() != 0) begin
            err_other++;
            $display("timeout in test %s, %0d expected beats never came out",
                     test_name, exp_q.size());
            exp_q.delete();
        end
        // quiet time to catch stray beats
        repeat (12) @(posedge rx_axis_aclk);
    endtask

    // outputs are registered, so mid-cycle values are settled
    always @(negedge rx_axis_aclk) begin
        if (rx_axis_aresetn) begin
            if (udp_rx_axis_tvalid) begin
                assert (exp_q.size() != 0) else begin
                    err_other++;
                    $display("unexpected output beat in test %s", test_name);
                end
                if (exp_q.size() != 0) begin
                    exp_beat = exp_q.pop_front();
                    assert ((udp_rx_axis_tdata & keep_mask(exp_beat.tkeep)) ==
                            (exp_beat.tdata & keep_mask(exp_beat.tkeep))) else begin
                        err_data++;
                        $display("FAILED %s tdata expected %h actual %h", test_name,
                                 exp_beat.tdata & keep_mask(exp_beat.tkeep),
                                 udp_rx_axis_tdata);
                    end
                    assert (udp_rx_axis_tkeep == exp_beat.tkeep) else begin
                        err_keep++;
                        $display("FAILED %s tkeep expected %h actual %h", test_name,
                                 exp_beat.tkeep, udp_rx_axis_tkeep);
                    end
                    assert (udp_rx_axis_tlast == exp_beat.tlast) else begin
                        err_last++;
                        $display("FAILED %s tlast expected %b actual %b", test_name,
                                 exp_beat.tlast, udp_rx_axis_tlast);
                    end
                end
            end else begin
                assert (!udp_rx_axis_tlast) else begin
                    err_other++;
                    $display("tlast high without tvalid in test %s", test_name);
                end
            end
        end
    end

    initial begin
        lfsr = 32'hc6ff;
        err_data = 0;
        err_keep = 0;
        err_last = 0;
        err_other = 0;
        test_name = "reset";
        rx_axis_aresetn = 1'b0;
        ip_rx_axis_tdata = '0;
        ip_rx_axis_tkeep = '0;
        ip_rx_axis_tvalid = 1'b0;
        ip_rx_axis_tlast = 1'b0;
        ip_rx_axis_tuser = 1'b0;
        recv_src_ip_addr = '0;
        recv_dst_ip_addr = '0;
        repeat (4) @(posedge rx_axis_aclk);
        #1;
        rx_axis_aresetn = 1'b1;

        test_name = "idle";
        repeat (20) drive_idle();

        test_name = "aligned";
        send_packet(24, 0, 1'b0, 1'b0, 1);
        wait_drain(200);

        test_name = "odd_len";
        send_packet(13, 0, 1'b0, 1'b0, 1);
        wait_drain(200);

        // 10 payload bytes inside 24 bytes of frame
        test_name = "padded";
        send_packet(10, 14, 1'b0, 1'b0, 1);
        wait_drain(200);

        test_name = "bad_csum";
        send_packet(16, 0, 1'b1, 1'b0, 1);
        send_packet(20, 0, 1'b0, 1'b0, 2);
        wait_drain(200);

        test_name = "bad_user";
        send_packet(16, 0, 1'b0, 1'b1, 1);
        send_packet(9, 0, 1'b0, 1'b0, 2);
        wait_drain(200);

        test_name = "one_beat";
        take_bits(32, rnd);
        drive_beat({rnd, ~rnd}, 8'hff, 1'b1, 1'b0);
        drive_idle();
        send_packet(8, 0, 1'b0, 1'b0, 1);
        wait_drain(200);

        test_name = "burst";
        for (int p = 0; p < 6; p++) begin
            take_bits(6, rnd);
            take_bits(2, gap);
            send_packet(int'(rnd % 40) + 1, 0, 1'b0, 1'b0, int'(gap));
        end
        wait_drain(600);

        $display("errors: data %0d, keep %0d, last %0d, other %0d",
                 err_data, err_keep, err_last, err_other);
        if (err_data + err_keep + err_last + err_other == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* design/udp_rx_top.sv */
`timescale 1ns/1ps
`include "udp_rx_macros.svh"

module udp_rx_top (
    input  logic                      rx_axis_aclk,
    input  logic                      rx_axis_aresetn,
    input  logic [`UDP_RX_DATA_W-1:0] ip_rx_axis_tdata,
    input  logic [`UDP_RX_KEEP_W-1:0] ip_rx_axis_tkeep,
    input  logic                      ip_rx_axis_tvalid,
    input  logic                      ip_rx_axis_tlast,
    input  logic                      ip_rx_axis_tuser,
    input  logic [31:0]               recv_dst_ip_addr,
    input  logic [31:0]               recv_src_ip_addr,
    output logic [`UDP_RX_DATA_W-1:0] udp_rx_axis_tdata,
    output logic [`UDP_RX_KEEP_W-1:0] udp_rx_axis_tkeep,
    output logic                      udp_rx_axis_tvalid,
    output logic                      udp_rx_axis_tlast
);
    import udp_rx_pkg::*;

    ip_beat_t                  in_beat;
    logic                      pkt_clear;
    logic                      lane_add;
    lane_words_t               lane_words;
    lane_words_t               lane_sums;
    logic                      pkt_end;
    logic [15:0]               pseudo_sum;
    logic [15:0]               udp_len;
    logic [5:0]                beat_cnt;
    logic                      pkt_bad;
    logic                      pay_valid;
    logic [`UDP_RX_DATA_W-1:0] pay_data;
    logic                      verdict_valid;
    udp_verdict_t              verdict;

    assign in_beat = '{tdata: ip_rx_axis_tdata, tkeep: ip_rx_axis_tkeep, tlast: ip_rx_axis_tlast};

    udp_rx_header_parser i_parser (
        .rx_axis_aclk    (rx_axis_aclk),
        .rx_axis_aresetn (rx_axis_aresetn),
        .in_beat         (in_beat),
        .in_valid        (ip_rx_axis_tvalid),
        .in_bad          (ip_rx_axis_tuser),
        .src_ip          (recv_src_ip_addr),
        .dst_ip          (recv_dst_ip_addr),
        .pkt_clear       (pkt_clear),
        .lane_add        (lane_add),
        .lane_words      (lane_words),
        .pkt_end         (pkt_end),
        .pseudo_sum      (pseudo_sum),
        .udp_len         (udp_len),
        .beat_cnt        (beat_cnt),
        .pkt_bad         (pkt_bad),
        .pay_valid       (pay_valid),
        .pay_data        (pay_data)
    );

    for (genvar g = 0; g < `UDP_RX_LANES; g++) begin : g_lane
        udp_csum_lane i_lane (
            .rx_axis_aclk    (rx_axis_aclk),
            .rx_axis_aresetn (rx_axis_aresetn),
            .clear           (pkt_clear),
            .add             (lane_add),
            .word            (lane_words[g]),
            .sum             (lane_sums[g])
        );
    end

    udp_csum_verdict i_verdict (
        .rx_axis_aclk    (rx_axis_aclk),
        .rx_axis_aresetn (rx_axis_aresetn),
        .pkt_end         (pkt_end),
        .lane_sums       (lane_sums),
        .pseudo_sum      (pseudo_sum),
        .udp_len         (udp_len),
        .beat_cnt        (beat_cnt),
        .pkt_bad         (pkt_bad),
        .verdict_valid   (verdict_valid),
        .verdict         (verdict)
    );

    udp_rx_forwarder i_forwarder (
        .rx_axis_aclk    (rx_axis_aclk),
        .rx_axis_aresetn (rx_axis_aresetn),
        .pay_valid       (pay_valid),
        .pay_data        (pay_data),
        .verdict_valid   (verdict_valid),
        .verdict         (verdict),
        .out_tdata       (udp_rx_axis_tdata),
        .out_tkeep       (udp_rx_axis_tkeep),
        .out_tvalid      (udp_rx_axis_tvalid),
        .out_tlast       (udp_rx_axis_tlast)
    );

endmodule

/* design/udp_rx_forwarder.sv */
`timescale 1ns/1ps
`include "udp_rx_macros.svh"

module udp_rx_forwarder (
    input  logic                      rx_axis_aclk,
    input  logic                      rx_axis_aresetn,
    input  logic                      pay_valid,
    input  logic [`UDP_RX_DATA_W-1:0] pay_data,
    input  logic                      verdict_valid,
    input  udp_rx_pkg::udp_verdict_t  verdict,
    output logic [`UDP_RX_DATA_W-1:0] out_tdata,
    output logic [`UDP_RX_KEEP_W-1:0] out_tkeep,
    output logic                      out_tvalid,
    output logic                      out_tlast
);
    import udp_rx_pkg::*;

    localparam int DATA_AW = $clog2(`UDP_RX_DATA_DEPTH);
    localparam int VERD_AW = $clog2(`UDP_RX_VERDICT_DEPTH);

    typedef enum logic {
        SEND_IDLE,
        SEND_BEATS
    } send_state_t;

    logic [`UDP_RX_DATA_W-1:0] data_mem [`UDP_RX_DATA_DEPTH];
    logic [DATA_AW-1:0]        data_wr;
    logic [DATA_AW-1:0]        data_rd;
    udp_verdict_t              verd_mem [`UDP_RX_VERDICT_DEPTH];
    logic [VERD_AW:0]          verd_wr;
    logic [VERD_AW:0]          verd_rd;
    logic                      verd_empty;
    send_state_t               state;
    udp_verdict_t              cur;
    logic [5:0]                beat_idx;
    logic                      start;
    logic                      last_read;
    logic                      emit;
    logic                      emit_last;

    // data side has no empty flag, beats are always in before their verdict
    always_ff @(posedge rx_axis_aclk) begin
        if (pay_valid) begin
            data_mem[data_wr] <= pay_data;
        end
        if (verdict_valid) begin
            verd_mem[verd_wr[VERD_AW-1:0]] <= verdict;
        end
    end

    assign verd_empty = (verd_wr == verd_rd);
    assign start      = (state == SEND_IDLE) && !verd_empty;
    assign last_read  = (state == SEND_BEATS) && (beat_idx == cur.beat_cnt - 6'd1);
    assign emit       = (state == SEND_BEATS) && cur.good && (beat_idx < cur.out_beats);
    assign emit_last  = emit && (beat_idx == cur.out_beats - 6'd1);

    always_ff @(posedge rx_axis_aclk) begin
        if (!rx_axis_aresetn) begin
            data_wr  <= '0;
            data_rd  <= '0;
            verd_wr  <= '0;
            verd_rd  <= '0;
            state    <= SEND_IDLE;
            beat_idx <= 6'd0;
        end else begin
            if (pay_valid) begin
                data_wr <= data_wr + 1'b1;
            end
            if (verdict_valid) begin
                verd_wr <= verd_wr + 1'b1;
            end
            case (state)
                SEND_IDLE: begin
                    if (start) begin
                        verd_rd  <= verd_rd + 1'b1;
                        beat_idx <= 6'd0;
                        state    <= SEND_BEATS;
                    end
                end
                SEND_BEATS: begin
                    // every stored beat is read, kept or not
                    data_rd  <= data_rd + 1'b1;
                    beat_idx <= beat_idx + 6'd1;
                    if (last_read) begin
                        state <= SEND_IDLE;
                    end
                end
                default: begin
                    state <= SEND_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge rx_axis_aclk) begin
        if (start) begin
            cur <= verd_mem[verd_rd[VERD_AW-1:0]];
        end
    end

    always_ff @(posedge rx_axis_aclk) begin
        if (!rx_axis_aresetn) begin
            out_tvalid <= 1'b0;
            out_tlast  <= 1'b0;
        end else begin
            out_tvalid <= emit;
            out_tlast  <= emit_last;
        end
    end

    always_ff @(posedge rx_axis_aclk) begin
        out_tdata <= data_mem[data_rd];
        out_tkeep <= emit_last ? cur.last_keep : '1;
    end

endmodule

/* design/udp_csum_verdict.sv */
`timescale 1ns/1ps
`include "udp_rx_macros.svh"

module udp_csum_verdict (
    input  logic                     rx_axis_aclk,
    input  logic                     rx_axis_aresetn,
    input  logic                     pkt_end,
    input  udp_rx_pkg::lane_words_t  lane_sums,
    input  logic [15:0]              pseudo_sum,
    input  logic [15:0]              udp_len,
    input  logic [5:0]               beat_cnt,
    input  logic                     pkt_bad,
    output logic                     verdict_valid,
    output udp_rx_pkg::udp_verdict_t verdict
);
    import udp_rx_pkg::*;

    logic        end_d1;
    logic        end_d2;
    logic [15:0] ps_d1;
    logic [15:0] len_d1;
    logic [15:0] len_d2;
    logic [5:0]  cnt_d1;
    logic [5:0]  cnt_d2;
    logic        bad_d1;
    logic        bad_d2;
    logic [15:0] fold_lo;
    logic [15:0] fold_hi;
    logic [15:0] total;
    logic [15:0] pay_len;
    logic [15:0] beats_need;
    logic [2:0]  tail;

    always_ff @(posedge rx_axis_aclk) begin
        if (!rx_axis_aresetn) begin
            end_d1        <= 1'b0;
            end_d2        <= 1'b0;
            verdict_valid <= 1'b0;
        end else begin
            end_d1        <= pkt_end;
            end_d2        <= end_d1;
            verdict_valid <= end_d2;
        end
    end

    // header side may change right after pkt_end, so hold a copy
    always_ff @(posedge rx_axis_aclk) begin
        if (pkt_end) begin
            ps_d1  <= pseudo_sum;
            len_d1 <= udp_len;
            cnt_d1 <= beat_cnt;
            bad_d1 <= pkt_bad;
        end
    end

    // lanes hold the final add by now
    always_ff @(posedge rx_axis_aclk) begin
        fold_lo <= csum_add(lane_sums[0], lane_sums[1]);
        fold_hi <= csum_add(csum_add(lane_sums[2], lane_sums[3]), ps_d1);
        len_d2  <= len_d1;
        cnt_d2  <= cnt_d1;
        bad_d2  <= bad_d1;
    end

    always_comb begin
        total      = csum_add(fold_lo, fold_hi);
        pay_len    = len_d2 - 16'(`UDP_RX_HDR_BYTES);
        beats_need = (pay_len + 16'd7) >> 3;
        tail       = pay_len[2:0];
    end

    always_ff @(posedge rx_axis_aclk) begin
        if (end_d2) begin
            verdict.beat_cnt  <= cnt_d2;
            verdict.out_beats <= beats_need[5:0];
            verdict.last_keep <= (tail == 3'd0) ? 8'hff : (8'h01 << tail) - 8'h01;
            // length must also fit inside the beats that arrived
            verdict.good      <= (total == 16'hffff) && !bad_d2 &&
                                 (len_d2 >= 16'(`UDP_RX_HDR_BYTES)) &&
                                 (beats_need <= {10'd0, cnt_d2});
            verdict.pad       <= 7'd0;
        end
    end

endmodule

/* design/udp_rx_header_parser.sv */
`timescale 1ns/1ps
`include "udp_rx_macros.svh"

module udp_rx_header_parser (
    input  logic                      rx_axis_aclk,
    input  logic                      rx_axis_aresetn,
    input  udp_rx_pkg::ip_beat_t      in_beat,
    input  logic                      in_valid,
    input  logic                      in_bad,
    input  logic [31:0]               src_ip,
    input  logic [31:0]               dst_ip,
    output logic                      pkt_clear,
    output logic                      lane_add,
    output udp_rx_pkg::lane_words_t   lane_words,
    output logic                      pkt_end,
    output logic [15:0]               pseudo_sum,
    output logic [15:0]               udp_len,
    output logic [5:0]                beat_cnt,
    output logic                      pkt_bad,
    output logic                      pay_valid,
    output logic [`UDP_RX_DATA_W-1:0] pay_data
);
    import udp_rx_pkg::*;

    typedef enum logic {
        ST_HEADER,
        ST_PAYLOAD
    } state_t;

    state_t                    state;
    udp_first_word_u           beat_view;
    lane_words_t               masked_words;
    logic [`UDP_RX_KEEP_W-1:0] byte_en;
    logic [15:0]               ip_sum;
    logic [15:0]               pseudo_fold;
    logic                      hdr_take;
    logic                      pay_take;

    assign beat_view = in_beat.tdata;

    // a lone beat with tlast in header state never starts a packet
    assign hdr_take = in_valid && (state == ST_HEADER) && !in_beat.tlast;
    assign pay_take = in_valid && (state == ST_PAYLOAD);

    // only the last beat may carry unused bytes
    assign byte_en = in_beat.tlast ? in_beat.tkeep : '1;

    // lower address byte becomes the high byte of the word
    always_comb begin
        for (int i = 0; i < `UDP_RX_LANES; i++) begin
            masked_words[i] = {beat_view.lanes[i][7:0] & {8{byte_en[2*i]}},
                               beat_view.lanes[i][15:8] & {8{byte_en[2*i+1]}}};
        end
    end

    // pseudo-header with the length taken from the header beat
    always_comb begin
        ip_sum = csum_add(csum_add(src_ip[31:16], src_ip[15:0]),
                          csum_add(dst_ip[31:16], dst_ip[15:0]));
        pseudo_fold = csum_add(ip_sum, csum_add(16'(`UDP_RX_PROTO), udp_len));
    end

    always_ff @(posedge rx_axis_aclk) begin
        if (!rx_axis_aresetn) begin
            state <= ST_HEADER;
        end else if (hdr_take) begin
            state <= ST_PAYLOAD;
        end else if (pay_take && in_beat.tlast) begin
            state <= ST_HEADER;
        end
    end

    always_ff @(posedge rx_axis_aclk) begin
        if (!rx_axis_aresetn) begin
            pkt_clear <= 1'b0;
            lane_add  <= 1'b0;
            pkt_end   <= 1'b0;
            pay_valid <= 1'b0;
            beat_cnt  <= 6'd0;
        end else begin
            pkt_clear <= hdr_take;
            lane_add  <= hdr_take || pay_take;
            pkt_end   <= pay_take && in_beat.tlast;
            pay_valid <= pay_take;
            // total is in place on the pkt_end cycle
            if (hdr_take) begin
                beat_cnt <= 6'd0;
            end else if (pay_take) begin
                beat_cnt <= beat_cnt + 6'd1;
            end
        end
    end

    always_ff @(posedge rx_axis_aclk) begin
        lane_words <= masked_words;
        pay_data   <= in_beat.tdata;
        if (hdr_take) begin
            udp_len <= {beat_view.hdr.length[7:0], beat_view.hdr.length[15:8]};
        end
        if (pay_take && in_beat.tlast) begin
            pseudo_sum <= pseudo_fold;
            pkt_bad    <= in_bad;
        end
    end

endmodule

/* design/udp_csum_lane.sv */
`timescale 1ns/1ps

module udp_csum_lane (
    input  logic        rx_axis_aclk,
    input  logic        rx_axis_aresetn,
    input  logic        clear,
    input  logic        add,
    input  logic [15:0] word,
    output logic [15:0] sum
);
    import udp_rx_pkg::*;

    // running sum of one word position over the whole packet
    always_ff @(posedge rx_axis_aclk) begin
        if (!rx_axis_aresetn) begin
            sum <= 16'h0000;
        end else if (clear) begin
            // a clear may come with the first word of the packet
            if (add) begin
                sum <= word;
            end else begin
                sum <= 16'h0000;
            end
        end else if (add) begin
            sum <= csum_add(sum, word);
        end
    end

endmodule

/* design/udp_rx_pkg.sv */
`include "udp_rx_macros.svh"

package udp_rx_pkg;

    // one beat of the ip payload stream
    typedef struct packed {
        logic [`UDP_RX_DATA_W-1:0] tdata;
        logic [`UDP_RX_KEEP_W-1:0] tkeep;
        logic                      tlast;
    } ip_beat_t;

    // raw header fields, byte 0 of the beat sits in the low bits
    // so src_port is the lowest field
    typedef struct packed {
        logic [15:0] checksum;
        logic [15:0] length;
        logic [15:0] dst_port;
        logic [15:0] src_port;
    } udp_header_t;

    typedef logic [`UDP_RX_LANES-1:0][15:0] lane_words_t;

    // first beat seen either as header fields or as lane words
    typedef union packed {
        udp_header_t hdr;
        lane_words_t lanes;
    } udp_first_word_u;

    typedef struct packed {
        logic [5:0] beat_cnt;
        logic [5:0] out_beats;
        logic [7:0] last_keep;
        logic       good;
        logic [6:0] pad;
    } udp_verdict_t;

    // one's complement add with end-around carry
    function automatic logic [15:0] csum_add(input logic [15:0] a, input logic [15:0] b);
        logic [16:0] sum;
        sum = a + b;
        return sum[15:0] + 16'(sum[16]);
    endfunction

endpackage

/* include/udp_rx_macros.svh */
`ifndef UDP_RX_MACROS_SVH
`define UDP_RX_MACROS_SVH

// stream width
`define UDP_RX_DATA_W 64
`define UDP_RX_KEEP_W 8

// one checksum lane per 16-bit word of a beat
`define UDP_RX_LANES 4

// protocol number that goes into the pseudo-header
`define UDP_RX_PROTO 17

// fixed udp header size in bytes
`define UDP_RX_HDR_BYTES 8

// payload beat buffer, holds two packets of 32 beats
`define UDP_RX_DATA_DEPTH 64

// one entry per packet waiting to be sent
`define UDP_RX_VERDICT_DEPTH 8

`endif
